/* rtl/noc_pkg.sv */
// Shared flit type, buffer depths and merge FSM encoding for the merge stage; widths are fixed at build time.
package noc_pkg;

   // width of the flit payload in bits.
   // the last marker travels beside the payload and is not part of it.
   localparam int FLIT_WIDTH = 32;

   // one flit of payload as it moves between buffers and the merge logic.
   // no field inside the payload has a meaning to the hardware.
   typedef logic [FLIT_WIDTH-1:0] flit_t;

   // depth of each input buffer in flits.
   // four entries are enough to cover the one cycle of buffer latency
   // plus a short burst while the mux serves the other port.
   localparam int IN_DEPTH = 4;

   // depth of the output buffer in flits.
   // it is deeper than the inputs so that a stalled output port
   // absorbs more than one short packet before the mux backs up.
   localparam int OUT_DEPTH = 8;

   // states of the packet merge FSM.
   // in idle the mux picks a port every cycle.
   // in a hold state the grant is locked to one port until the
   // flit with last set has been transferred.
   typedef enum logic [1:0] {
      MUX_IDLE  = 2'b00,
      MUX_HOLD0 = 2'b01,
      MUX_HOLD1 = 2'b10
   } mux_state_t;

endpackage

/* rtl/noc_flit_if.sv */
// Flit stream bundle with valid/ready; carries no clock, so both ends must sit in one clock domain.
`timescale 1ns/10ps

interface noc_flit_if;

   // payload of the flit that is currently offered.
   noc_pkg::flit_t flit;

   // marks the final flit of a packet.
   logic last;

   // the sender has a flit on flit and last.
   // it stays high until the flit has been taken.
   logic valid;

   // the receiver takes the flit on the next rising edge.
   logic ready;

   // the sender drives the flit and its qualifiers.
   // it must keep flit and last stable while valid is high and ready is low.
   modport sender (
      output flit,
      output last,
      output valid,
      input  ready
   );

   // the receiver only answers with ready.
   modport receiver (
      input  flit,
      input  last,
      input  valid,
      output ready
   );

endinterface

/* rtl/noc_buffer.sv */
// Shift-register flit FIFO; a push into a full buffer is refused even if a pop happens in the same cycle.
`timescale 1ns/10ps

module noc_buffer #(
   parameter int DEPTH = noc_pkg::IN_DEPTH
) (
   input  logic           clk,
   input  logic           rst,

   // write side.
   input  noc_pkg::flit_t in_flit,
   input  logic           in_last,
   input  logic           in_valid,
   output logic           in_ready,

   // read side.
   output noc_pkg::flit_t out_flit,
   output logic           out_last,
   output logic           out_valid,
   input  logic           out_ready
);

   // storage for the payload and the last marker of every entry.
   // entry 0 is the head and always drives the read side.
   noc_pkg::flit_t   flit_q [DEPTH];
   logic [DEPTH-1:0] last_q;

   // next contents of the shift register.
   noc_pkg::flit_t   flit_d [DEPTH];
   logic [DEPTH-1:0] last_d;

   // one-hot pointer to the next free entry.
   // bit 0 set means empty, bit DEPTH set means full.
   logic [DEPTH:0]   wr_ptr;

   logic             push;
   logic             pop;

   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   // the write side only looks at the fill level.
   // this keeps out_ready off the path to in_ready.
   assign in_ready  = ~wr_ptr[DEPTH];
   assign out_valid = ~wr_ptr[0];
   assign out_flit  = flit_q[0];
   assign out_last  = last_q[0];

   // the pointer moves up on a push alone and down on a pop alone.
   // a push and a pop together leave the fill level unchanged.
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= {{DEPTH{1'b0}}, 1'b1};
      end else if (push && !pop) begin
         wr_ptr <= wr_ptr << 1;
      end else if (pop && !push) begin
         wr_ptr <= wr_ptr >> 1;
      end
   end

   // every entry either keeps its value, takes the one above it on a pop,
   // or takes the incoming flit.
   // on a pop the free slot is one below the pointer, because all
   // entries move down by one in the same edge.
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         flit_d[i] = flit_q[i];
         last_d[i] = last_q[i];
         if (pop) begin
            if (push && wr_ptr[i+1]) begin
               flit_d[i] = in_flit;
               last_d[i] = in_last;
            end else if (i < DEPTH-1) begin
               flit_d[i] = flit_q[i+1];
               last_d[i] = last_q[i+1];
            end
         end else if (push && wr_ptr[i]) begin
            flit_d[i] = in_flit;
            last_d[i] = in_last;
         end
      end
   end

   // the shift register loads its next contents on every edge.
   // entries at or above the pointer hold stale data until a push fills them.
   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         flit_q[i] <= flit_d[i];
      end
      last_q <= last_d;
   end

   // a stalled head must stay put until the reader takes it.
   // this holds only if nothing but a pop ever moves entry 0.
   property p_out_stable;
      @(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_flit) && $stable(out_last);
   endproperty

   a_out_stable: assert property (p_out_stable)
      else $error("buffer head changed while stalled");

   // the fill pointer must never lose or gain a bit across updates.
   a_ptr_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(wr_ptr))
      else $error("buffer fill pointer is not one-hot");

endmodule

/* rtl/noc_mux.sv */
// Packet round-robin merge of two flit streams; assumes every packet ends with a flit that has last set.
`timescale 1ns/10ps

module noc_mux (
   input  logic         clk,
   input  logic         rst,
   noc_flit_if.receiver in0,
   noc_flit_if.receiver in1,
   noc_flit_if.sender   out
);

   noc_pkg::mux_state_t state;
   noc_pkg::mux_state_t state_next;

   // port that finished the most recent packet.
   // a set bit means port 1.
   logic last_served;

   // port that is selected in this cycle.
   logic gnt;

   // high when some port is selected, either locked or newly picked.
   logic active;

   // a flit leaves the mux on this edge.
   logic xfer;

   // grant selection.
   // a hold state pins the grant to its port.
   // in idle a lone valid port wins, and a tie goes to the port that
   // was not served last.
   always_comb begin
      gnt    = 1'b0;
      active = 1'b0;
      case (state)
         noc_pkg::MUX_HOLD0: begin
            gnt    = 1'b0;
            active = 1'b1;
         end
         noc_pkg::MUX_HOLD1: begin
            gnt    = 1'b1;
            active = 1'b1;
         end
         default: begin
            active = in0.valid | in1.valid;
            if (in0.valid && in1.valid) begin
               gnt = ~last_served;
            end else begin
               gnt = in1.valid;
            end
         end
      endcase
   end

   // the data path is a plain select, so the first flit of a packet
   // passes in the same cycle that its grant is picked.
   assign out.flit  = gnt ? in1.flit : in0.flit;
   assign out.last  = gnt ? in1.last : in0.last;
   assign out.valid = active & (gnt ? in1.valid : in0.valid);

   // ready goes back only to the granted port.
   assign in0.ready = active & ~gnt & out.ready;
   assign in1.ready = active & gnt & out.ready;

   assign xfer = out.valid & out.ready;

   // a packet ends when its last flit is transferred.
   // otherwise the grant locks as soon as a flit is offered.
   // locking before the first transfer keeps the offered flit stable
   // while the output buffer is full.
   always_comb begin
      state_next = state;
      if (xfer && out.last) begin
         state_next = noc_pkg::MUX_IDLE;
      end else if (state == noc_pkg::MUX_IDLE && out.valid) begin
         state_next = gnt ? noc_pkg::MUX_HOLD1 : noc_pkg::MUX_HOLD0;
      end
   end

   // port 1 counts as served after reset, so port 0 wins the first tie.
   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= noc_pkg::MUX_IDLE;
         last_served <= 1'b1;
      end else begin
         state <= state_next;
         if (xfer && out.last) begin
            last_served <= gnt;
         end
      end
   end

   // once a flit has been offered, the grant stays on that port
   // until the packet's last flit has gone through.
   property p_grant_held;
      @(posedge clk) disable iff (rst)
      out.valid && !(out.ready && out.last) |=> gnt == $past(gnt);
   endproperty

   a_grant_held: assert property (p_grant_held)
      else $error("grant moved in the middle of a packet");

   // after a flit from the middle of a packet has been taken, the other
   // port must not be acknowledged on the next cycle.
   a_no_ready0: assert property (@(posedge clk) disable iff (rst)
      in1.valid && in1.ready && !in1.last |=> !in0.ready)
      else $error("port 0 saw ready while port 1 holds the grant");

   a_no_ready1: assert property (@(posedge clk) disable iff (rst)
      in0.valid && in0.ready && !in0.last |=> !in1.ready)
      else $error("port 1 saw ready while port 0 holds the grant");

endmodule

/* rtl/noc_merge_top.sv */
// Two-input packet merge stage; flits need one clock and two cycles of latency when the path is idle.
`timescale 1ns/10ps

module noc_merge_top (
   input  logic           clk,
   input  logic           rst,

   // input port 0.
   input  noc_pkg::flit_t in0_flit,
   input  logic           in0_last,
   input  logic           in0_valid,
   output logic           in0_ready,

   // input port 1.
   input  noc_pkg::flit_t in1_flit,
   input  logic           in1_last,
   input  logic           in1_valid,
   output logic           in1_ready,

   // merged output port.
   output noc_pkg::flit_t out_flit,
   output logic           out_last,
   output logic           out_valid,
   input  logic           out_ready
);

   // streams from the input buffers into the mux.
   noc_flit_if buf0 ();
   noc_flit_if buf1 ();

   // stream from the mux into the output buffer.
   noc_flit_if merged ();

   // each input gets its own shallow buffer.
   // this decouples the two senders, so one stalled port does not hold
   // up a packet that the mux is taking from the other.
   noc_buffer #(
      .DEPTH(noc_pkg::IN_DEPTH)
   ) in0_buf (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in0_flit),
      .in_last   (in0_last),
      .in_valid  (in0_valid),
      .in_ready  (in0_ready),
      .out_flit  (buf0.flit),
      .out_last  (buf0.last),
      .out_valid (buf0.valid),
      .out_ready (buf0.ready)
   );

   noc_buffer #(
      .DEPTH(noc_pkg::IN_DEPTH)
   ) in1_buf (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in1_flit),
      .in_last   (in1_last),
      .in_valid  (in1_valid),
      .in_ready  (in1_ready),
      .out_flit  (buf1.flit),
      .out_last  (buf1.last),
      .out_valid (buf1.valid),
      .out_ready (buf1.ready)
   );

   // the mux forwards one whole packet at a time with no added latency.
   noc_mux merge (
      .clk (clk),
      .rst (rst),
      .in0 (buf0.receiver),
      .in1 (buf1.receiver),
      .out (merged.sender)
   );

   // the deeper output buffer registers the merged stream.
   // it also absorbs stalls on the output port.
   noc_buffer #(
      .DEPTH(noc_pkg::OUT_DEPTH)
   ) out_buf (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (merged.flit),
      .in_last   (merged.last),
      .in_valid  (merged.valid),
      .in_ready  (merged.ready),
      .out_flit  (out_flit),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

endmodule

/* bench/noc_merge_model.svh */
// Reference model of the merge stage; include it inside the testbench module after NUM_PKTS and SAT_PKTS.
`ifndef NOC_MERGE_MODEL_SVH
`define NOC_MERGE_MODEL_SVH

// flits that each input has accepted and the output has not yet delivered.
// the oldest flit sits at the front of each queue.
noc_pkg::flit_t exp_flit0 [$];
logic           exp_last0 [$];
noc_pkg::flit_t exp_flit1 [$];
logic           exp_last1 [$];

// output packet tracking.
// in_packet is high between the first flit and the last flit of a packet.
logic in_packet;
logic cur_src;
int   rx_packets;

// record a flit that an input port has just accepted.
task automatic model_push(input logic port, input noc_pkg::flit_t flit, input logic last);
   if (port) begin
      exp_flit1.push_back(flit);
      exp_last1.push_back(last);
   end else begin
      exp_flit0.push_back(flit);
      exp_last0.push_back(last);
   end
endtask

// match one flit taken at the output against the head of its source queue.
// bit 31 of the payload names the source port.
task automatic check_output(input noc_pkg::flit_t flit, input logic last);
   noc_pkg::flit_t exp_flit;
   logic           exp_last;
   logic           src;
   src = flit[31];
   if (in_packet && src != cur_src) begin
      stop_run($sformatf("a flit from port %0d cut into a packet from port %0d", src, cur_src));
   end
   if ((src && exp_flit1.size() == 0) || (!src && exp_flit0.size() == 0)) begin
      stop_run($sformatf("output flit %h from port %0d had no pending input flit", flit, src));
   end
   if (src) begin
      exp_flit = exp_flit1.pop_front();
      exp_last = exp_last1.pop_front();
   end else begin
      exp_flit = exp_flit0.pop_front();
      exp_last = exp_last0.pop_front();
   end
   compare_flit("out_flit", exp_flit, flit);
   compare_last("out_last", exp_last, last);
   // while both inputs are saturated the packets must alternate, port 0 first.
   if (!in_packet && rx_packets < 2 * SAT_PKTS && src != rx_packets[0]) begin
      stop_run($sformatf("packet %0d came from port %0d, so round robin was not kept",
                         rx_packets, src));
   end
   in_packet = !last;
   cur_src   = src;
   if (last) begin
      rx_packets++;
   end
endtask

`endif

/* bench/noc_merge_tb.sv */
// Random merge test with a fixed seed; the first SAT_PKTS packets per port run saturated with no stall.
`timescale 1ns/10ps

module noc_merge_tb;

   // packets sent by each input.
   localparam int NUM_PKTS = 40;

   // packets per input sent back to back with the output never stalled.
   localparam int SAT_PKTS = 10;

   // longest packet in flits.
   localparam int MAX_LEN = 6;

   // worst case of three cycles per flit for every packet, plus slack for reset and drain.
   localparam int TIMEOUT_NS = 2 * NUM_PKTS * MAX_LEN * 3 * 8 + 2000;

   logic           clk;
   logic           rst;
   noc_pkg::flit_t in0_flit;
   logic           in0_last;
   logic           in0_valid;
   logic           in0_ready;
   noc_pkg::flit_t in1_flit;
   logic           in1_last;
   logic           in1_valid;
   logic           in1_ready;
   noc_pkg::flit_t out_flit;
   logic           out_last;
   logic           out_valid;
   logic           out_ready;

   // sender progress per input port.
   int pkt_num [2];
   int flit_idx [2];
   int pkt_len [2];

   // state of the LCG.
   logic [31:0] lcg_state;

   // output head as seen on a stalled cycle.
   logic           stall_seen;
   noc_pkg::flit_t held_flit;
   logic           held_last;

   `include "noc_merge_model.svh"

   noc_merge_top UUT (
      .clk       (clk),
      .rst       (rst),
      .in0_flit  (in0_flit),
      .in0_last  (in0_last),
      .in0_valid (in0_valid),
      .in0_ready (in0_ready),
      .in1_flit  (in1_flit),
      .in1_last  (in1_last),
      .in1_valid (in1_valid),
      .in1_ready (in1_ready),
      .out_flit  (out_flit),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   always #4 clk = ~clk;

   // the upper bits of the LCG are the most random ones.
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {8'd0, lcg_state[31:8]};
   endfunction

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic compare_flit(input string name, input noc_pkg::flit_t exp,
                               input noc_pkg::flit_t act);
      if (act !== exp) begin
         stop_run($sformatf("** Error at time %0t: %s expected %h, got %h",
                            $time, name, exp, act));
      end
   endtask

   task automatic compare_last(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stop_run($sformatf("** Error at time %0t: %s expected %b, got %b",
                            $time, name, exp, act));
      end
   endtask

   task automatic compare_status(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stop_run($sformatf("** Error at time %0t: %s expected %b, got %b",
                            $time, name, exp, act));
      end
   endtask

   // next values of one sender from its current handshake.
   // a stalled flit is held, and valid only drops after a transfer.
   task automatic drive_port(input logic port, input logic valid, input logic ready,
                             input noc_pkg::flit_t flit, input logic last,
                             output noc_pkg::flit_t nxt_flit, output logic nxt_last,
                             output logic nxt_valid);
      logic [31:0] r;
      nxt_flit  = flit;
      nxt_last  = last;
      nxt_valid = valid;
      if (valid && ready) begin
         model_push(port, flit, last);
         if (last) begin
            pkt_num[port]++;
            flit_idx[port] = 0;
         end else begin
            flit_idx[port]++;
         end
      end
      if (!valid || ready) begin
         r = next_rand();
         if (pkt_num[port] >= NUM_PKTS) begin
            nxt_valid = 1'b0;
         end else if (pkt_num[port] >= SAT_PKTS && r % 4 == 0) begin
            // idle gaps only appear once the saturated stretch is over.
            nxt_valid = 1'b0;
         end else begin
            if (flit_idx[port] == 0) begin
               pkt_len[port] = 1 + next_rand() % MAX_LEN;
            end
            nxt_flit  = {port, pkt_num[port][14:0], r[15:0]};
            nxt_last  = (flit_idx[port] == pkt_len[port] - 1);
            nxt_valid = 1'b1;
         end
      end
   endtask

   // stimulus.
   always @(posedge clk) begin
      noc_pkg::flit_t f;
      logic           l;
      logic           v;
      if (rst) begin
         in0_valid <= 1'b0;
         in1_valid <= 1'b0;
         out_ready <= 1'b0;
      end else begin
         drive_port(1'b0, in0_valid, in0_ready, in0_flit, in0_last, f, l, v);
         in0_flit  <= f;
         in0_last  <= l;
         in0_valid <= v;
         drive_port(1'b1, in1_valid, in1_ready, in1_flit, in1_last, f, l, v);
         in1_flit  <= f;
         in1_last  <= l;
         in1_valid <= v;
         if (pkt_num[0] < SAT_PKTS || pkt_num[1] < SAT_PKTS) begin
            out_ready <= 1'b1;
         end else begin
            out_ready <= (next_rand() % 3 != 0);
         end
      end
   end

   // output monitor.
   // a head offered without ready must still be there one cycle later.
   always @(posedge clk) begin
      if (!rst) begin
         if (stall_seen) begin
            compare_status("out_valid", 1'b1, out_valid);
            compare_flit("out_flit", held_flit, out_flit);
            compare_last("out_last", held_last, out_last);
         end
         stall_seen = out_valid && !out_ready;
         held_flit  = out_flit;
         held_last  = out_last;
         if (out_valid && out_ready) begin
            check_output(out_flit, out_last);
         end
      end
   end

   // watchdog.
   initial begin
      #(TIMEOUT_NS);
      stop_run($sformatf("the run timed out after %0d ns with %0d packets received",
                         TIMEOUT_NS, rx_packets));
   end

   initial begin
      lcg_state  = 32'hefe70a3e;
      clk        = 1'b0;
      rst        = 1'b1;
      in0_flit   = '0;
      in0_last   = 1'b0;
      in0_valid  = 1'b0;
      in1_flit   = '0;
      in1_last   = 1'b0;
      in1_valid  = 1'b0;
      out_ready  = 1'b0;
      stall_seen = 1'b0;
      in_packet  = 1'b0;
      cur_src    = 1'b0;
      rx_packets = 0;
      for (int p = 0; p < 2; p++) begin
         pkt_num[p]  = 0;
         flit_idx[p] = 0;
         pkt_len[p]  = 1;
      end
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      // the first cycle out of reset shows an empty stage.
      @(posedge clk);
      compare_status("out_valid", 1'b0, out_valid);
      compare_status("in0_ready", 1'b1, in0_ready);
      compare_status("in1_ready", 1'b1, in1_ready);
      wait (rx_packets == 2 * NUM_PKTS);
      // a few more cycles let a duplicated flit show up at the output.
      repeat (4) @(posedge clk);
      if (exp_flit0.size() != 0 || exp_flit1.size() != 0 || out_valid) begin
         stop_run("flits were still pending after all packets had been received");
      end else begin
         $display("test passed");
         $finish;
      end
   end

endmodule

/* vlog.f */
+incdir+bench
rtl/noc_pkg.sv
rtl/noc_flit_if.sv
rtl/noc_buffer.sv
rtl/noc_mux.sv
rtl/noc_merge_top.sv
bench/noc_merge_tb.sv
